// File: tb.f
hw/mem_pkg.sv
hw/cache_array.sv
hw/four_bank_mem.sv
hw/cache_ctrl.sv
hw/mem_system.sv
verification/mem_checker.sv
verification/tb_mem_system.sv

// File: verification/tb_mem_system.sv
// Memory system testbench
// Random processor requests on falling edges over a small set of tags,
// indices and words, checked by mem_checker, with a cycle limit
`default_nettype none

module tb_mem_system import mem_pkg::*; ();

   localparam int num_reqs   = 400;
   localparam int max_cycles = num_reqs * 40;

   // Address pools, four entries each
   localparam logic [4*tag_w-1:0]   tag_pool   = {5'h1f, 5'h13, 5'h05, 5'h00};
   localparam logic [4*index_w-1:0] index_pool = {8'hff, 8'h7e, 8'h01, 8'h00};

   logic              clk;
   logic              reset;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [data_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;
   int                err_count;
   int                req_count;
   int                cycle_cnt = 0;
   integer            seed;

   // Busy window longer than a burst, so line fills meet bank stalls
   mem_system #(
      .read_latency     (2),
      .bank_busy_cycles (6)
   ) i_dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   mem_checker i_checker (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .err_count (err_count),
      .req_count (req_count)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Run length guard
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   // Random request on the current falling edge
   task automatic drive_request();
      int sel_tag;
      int sel_idx;
      int kind;
      sel_tag = $unsigned($random(seed)) % 4;
      sel_idx = $unsigned($random(seed)) % 4;
      kind    = $unsigned($random(seed)) % 100;
      addr    = {tag_pool[sel_tag*tag_w +: tag_w], index_pool[sel_idx*index_w +: index_w],
                 2'($unsigned($random(seed)) % 4), 1'b0};
      data_in = 16'($random(seed));
      rd      = 1'($unsigned($random(seed)) % 2);
      wr      = !rd;
      // Roughly 5 percent bad requests
      if (kind < 3) begin
         addr[0] = 1'b1;
      end else if (kind < 5) begin
         rd = 1'b1;
         wr = 1'b1;
      end
   endtask

   // Hold until done, then drop the strobes and idle a little
   task automatic run_request();
      int gap;
      drive_request();
      @(posedge clk);
      while (!done) begin
         @(posedge clk);
      end
      @(negedge clk);
      rd  = 1'b0;
      wr  = 1'b0;
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk);
   endtask

   initial begin
      seed    = 32'he159;
      reset   = 1'b1;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      for (int n = 0; n < num_reqs; n++) begin
         run_request();
      end
      repeat (4) @(negedge clk);
      $display("Requests checked: %0d, errors: %0d", req_count, err_count);
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/mem_checker.sv
// Memory system checker
// Watches the processor ports, keeps a flat word model and a per-index
// tag model, and compares data, hit flag, error flag and timing
`default_nettype none

module mem_checker import mem_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   input  logic [data_w-1:0] data_out,
   input  logic              done,
   input  logic              stall,
   input  logic              cache_hit,
   input  logic              err,
   output int                err_count,
   output int                req_count
);

   // Request captured in its first cycle, with its predictions
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic              rd;
      logic              bad;
      logic              hit;
   } pend_req_t;

   // Flat word model and line tags
   logic [data_w-1:0] word_model [2 ** (addr_w - 1)];
   logic              line_valid [2 ** index_w];
   logic [tag_w-1:0]  line_tag   [2 ** index_w];

   pend_req_t cur;
   logic      busy;
   int        cyc;

   initial begin
      for (int i = 0; i < 2 ** (addr_w - 1); i++) begin
         word_model[i] = '0;
      end
      for (int i = 0; i < 2 ** index_w; i++) begin
         line_valid[i] = 1'b0;
         line_tag[i]   = '0;
      end
      err_count = 0;
      req_count = 0;
      busy      = 1'b0;
      cyc       = 0;
   end

   task automatic compare_value(input string sig, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         $display("ERR t=%0t %s expected %0h got %0h", $time, sig, exp_v, act_v);
         err_count++;
      end
   endtask

   // Outputs at done, then model update
   task automatic close_request();
      logic [index_w-1:0] idx;
      idx = cur.addr[10:3];
      compare_value("stall", 0, stall);
      compare_value("err", cur.bad, err);
      if (cur.bad) begin
         compare_value("cache_hit", 0, cache_hit);
         compare_value("done cycle", 2, cyc);
      end else begin
         compare_value("cache_hit", cur.hit, cache_hit);
         if (cur.hit) begin
            compare_value("done cycle", 3, cyc);
         end else if (cyc <= 3) begin
            $display("ERR t=%0t done cycle expected above 3 got %0d", $time, cyc);
            err_count++;
         end
         if (cur.rd) begin
            compare_value("data_out", word_model[cur.addr[15:1]], data_out);
         end else begin
            word_model[cur.addr[15:1]] = cur.data;
         end
         // Line now holds this tag
         line_valid[idx] = 1'b1;
         line_tag[idx]   = cur.addr[15:11];
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         busy = 1'b0;
         cyc  = 0;
      end else begin
         // New request seen in its idle cycle
         if (!busy && (rd || wr)) begin
            busy     = 1'b1;
            cyc      = 0;
            cur.addr = addr;
            cur.data = data_in;
            cur.rd   = rd;
            cur.bad  = (rd && wr) || addr[0];
            cur.hit  = !cur.bad && line_valid[addr[10:3]] &&
                       line_tag[addr[10:3]] == addr[15:11];
            req_count++;
         end
         if (busy) begin
            cyc++;
            if (done) begin
               close_request();
               busy = 1'b0;
            end else begin
               compare_value("stall", 1, stall);
               compare_value("err", 0, err);
               compare_value("cache_hit", 0, cache_hit);
               // Missing done at the fixed cycle
               if ((cur.bad && cyc == 2) || (cur.hit && cyc == 3)) begin
                  compare_value("done", 1, done);
               end
            end
         end else begin
            // Quiet outputs with nothing pending
            compare_value("done", 0, done);
            compare_value("stall", 0, stall);
            compare_value("err", 0, err);
            compare_value("cache_hit", 0, cache_hit);
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/mem_system.sv
// Memory system top level
// Direct-mapped write-back cache in front of a four-bank memory,
// sequenced by the cache controller
`default_nettype none

module mem_system import mem_pkg::*; #(
   parameter int read_latency     = 2,
   parameter int bank_busy_cycles = 4
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [data_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   // Controller to cache and memory
   cache_req_t cache_req;
   cache_rsp_t cache_rsp;
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;

   cache_ctrl #(
      .read_latency (read_latency)
   ) i_cache_ctrl (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .cache_rsp (cache_rsp),
      .mem_rsp   (mem_rsp),
      .cache_req (cache_req),
      .mem_req   (mem_req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   cache_array i_cache_array (
      .clk       (clk),
      .reset     (reset),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp)
   );

   four_bank_mem #(
      .read_latency     (read_latency),
      .bank_busy_cycles (bank_busy_cycles)
   ) i_four_bank_mem (
      .clk     (clk),
      .reset   (reset),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
// Cache controller
// Compares the request against the cache, writes back a dirty victim,
// fills the line from the banked memory and replays the compare
`default_nettype none

module cache_ctrl import mem_pkg::*; #(
   parameter int read_latency = 2
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   input  cache_rsp_t        cache_rsp,
   input  mem_rsp_t          mem_rsp,
   output cache_req_t        cache_req,
   output mem_req_t          mem_req,
   output logic [data_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   localparam int cnt_w = $clog2(words_per_line) + 1;
   localparam logic [cnt_w-1:0] all_words = cnt_w'(words_per_line);
   localparam logic [cnt_w-1:0] last_word = cnt_w'(words_per_line - 1);

   typedef enum logic [2:0] {
      s_idle, s_compare, s_check, s_writeback, s_fill, s_fill_wait, s_replay
   } state_t;

   state_t           state;
   state_t           state_nxt;
   cache_addr_u      req_addr;
   cache_addr_u      issue_addr;
   cache_addr_u      ret_addr;
   cache_addr_u      victim_addr;
   logic [tag_w-1:0] victim_tag;
   // Words issued and words completed in the current burst
   logic [cnt_w-1:0] issue_cnt;
   logic [cnt_w-1:0] ret_cnt;
   logic             issue_inc;
   logic             ret_inc;
   logic             cnt_clr;
   logic             req;
   logic             req_bad;
   logic             real_hit;
   logic             wb_pend;
   logic             wr_acc;
   logic             err_q;
   logic             miss_q;

   assign req_addr = addr;
   assign req      = rd | wr;
   // Odd address or both strobes
   assign req_bad  = (rd & wr) | addr[0];
   assign real_hit = cache_rsp.hit & cache_rsp.valid;
   assign data_out = cache_rsp.data;
   assign stall    = req & ~done;

   // Burst addresses by word counter
   always_comb begin
      issue_addr            = req_addr;
      issue_addr.f.word     = issue_cnt[cnt_w-2:0];
      issue_addr.f.byte_sel = 1'b0;
      ret_addr              = issue_addr;
      ret_addr.f.word       = ret_cnt[cnt_w-2:0];
      // Victim goes back under its old tag
      victim_addr           = ret_addr;
      victim_addr.f.tag     = victim_tag;
   end

   always_comb begin
      state_nxt = state;
      cache_req = '0;
      mem_req   = '0;
      issue_inc = 1'b0;
      ret_inc   = 1'b0;
      cnt_clr   = 1'b0;
      done      = 1'b0;
      err       = 1'b0;
      cache_hit = 1'b0;
      wb_pend   = 1'b0;
      wr_acc    = 1'b0;
      case (state)
         s_idle: begin
            cnt_clr = 1'b1;
            if (req) begin
               state_nxt = req_bad ? s_check : s_compare;
            end
         end
         // Compare access, writes land only on a hit
         s_compare, s_replay: begin
            cache_req.en    = 1'b1;
            cache_req.comp  = 1'b1;
            cache_req.write = wr;
            cache_req.addr  = req_addr;
            cache_req.data  = data_in;
            state_nxt       = s_check;
         end
         s_check: begin
            cnt_clr = 1'b1;
            if (err_q) begin
               done      = 1'b1;
               err       = 1'b1;
               state_nxt = s_idle;
            end else if (real_hit) begin
               done      = 1'b1;
               cache_hit = ~miss_q;
               state_nxt = s_idle;
            end else if (cache_rsp.valid && cache_rsp.dirty) begin
               state_nxt = s_writeback;
            end else begin
               state_nxt = s_fill;
            end
         end
         // Array read one cycle ahead of each bank write
         s_writeback: begin
            wb_pend       = issue_cnt != ret_cnt;
            wr_acc        = wb_pend & ~mem_rsp.stall;
            mem_req.wr    = wb_pend;
            mem_req.addr  = victim_addr.flat;
            mem_req.data  = cache_rsp.data;
            ret_inc       = wr_acc;
            // Next word only once the held one is taken
            if (issue_cnt != all_words && (!wb_pend || wr_acc)) begin
               cache_req.en   = 1'b1;
               cache_req.addr = issue_addr;
               issue_inc      = 1'b1;
            end
            if (wr_acc && ret_cnt == last_word) begin
               cnt_clr   = 1'b1;
               state_nxt = s_fill;
            end
         end
         s_fill, s_fill_wait: begin
            if (state == s_fill) begin
               mem_req.rd   = 1'b1;
               mem_req.addr = issue_addr.flat;
               issue_inc    = ~mem_rsp.stall;
               if (!mem_rsp.stall && issue_cnt == last_word) begin
                  state_nxt = s_fill_wait;
               end
            end
            // Returning words go straight into the line
            if (mem_rsp.data_valid) begin
               cache_req.en       = 1'b1;
               cache_req.write    = 1'b1;
               cache_req.valid_in = 1'b1;
               cache_req.addr     = ret_addr;
               cache_req.data     = mem_rsp.data;
               ret_inc            = 1'b1;
               if (ret_cnt == last_word) begin
                  cnt_clr   = 1'b1;
                  state_nxt = s_replay;
               end
            end
         end
         default: state_nxt = s_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= s_idle;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         err_q     <= 1'b0;
         miss_q    <= 1'b0;
      end else begin
         state <= state_nxt;
         err_q <= (state == s_idle) && req && req_bad;
         // Miss flag holds until the request finishes
         if (state == s_idle) begin
            miss_q <= 1'b0;
         end else if (state == s_check && !err_q && !real_hit) begin
            miss_q <= 1'b1;
         end
         if (cnt_clr) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
         end else begin
            if (issue_inc) begin
               issue_cnt <= issue_cnt + 1'b1;
            end
            if (ret_inc) begin
               ret_cnt <= ret_cnt + 1'b1;
            end
         end
      end
   end

   // Victim tag from the first compare
   always_ff @(posedge clk) begin
      if (state == s_check) begin
         victim_tag <= cache_rsp.tag_out;
      end
   end

   // Replayed compare always finds the freshly filled line
   assert property (@(posedge clk) disable iff (reset)
      state == s_replay |=> real_hit);

   // A stalled memory strobe is held unchanged until taken
   assert property (@(posedge clk) disable iff (reset)
      (mem_req.rd || mem_req.wr) && mem_rsp.stall |=> $stable(mem_req));

   // Accepted fill reads come back after the fixed latency
   assert property (@(posedge clk) disable iff (reset)
      mem_req.rd && !mem_rsp.stall |-> ##read_latency mem_rsp.data_valid);

endmodule

`default_nettype wire

// File: hw/four_bank_mem.sv
// Four-bank interleaved word memory
// Banks are picked by address bits 2:1 and stay busy for a few cycles
// after each access. Reads return after a fixed latency, in order
`default_nettype none

module four_bank_mem import mem_pkg::*; #(
   parameter int read_latency     = 2,
   parameter int bank_busy_cycles = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  mem_req_t mem_req,
   output mem_rsp_t mem_rsp
);

   localparam int bank_w = $clog2(words_per_line);
   localparam int row_w  = addr_w - bank_w - 1;
   localparam int busy_w = $clog2(bank_busy_cycles + 1);

   logic [data_w-1:0] bank_mem [words_per_line][2 ** row_w];

   logic [busy_w-1:0]          busy_cnt [words_per_line];
   logic [words_per_line-1:0]  bank_busy;
   logic [words_per_line-1:0]  bank_acc;
   logic [bank_w-1:0]          bank_sel;
   logic [row_w-1:0]           row;
   logic                       strobe;
   logic                       rd_acc;
   logic                       wr_acc;

   // Read return pipeline
   logic [read_latency-1:0]    vld_pipe;
   logic [data_w-1:0]          data_pipe [read_latency];

   assign bank_sel = mem_req.addr[bank_w:1];
   assign row      = mem_req.addr[addr_w-1:bank_w+1];
   assign strobe   = mem_req.rd | mem_req.wr;

   always_comb begin
      for (int b = 0; b < words_per_line; b++) begin
         bank_busy[b] = busy_cnt[b] != '0;
         bank_acc[b]  = strobe && (bank_sel == bank_w'(b)) && !bank_busy[b];
      end
   end

   assign rd_acc = mem_req.rd & ~bank_busy[bank_sel];
   assign wr_acc = mem_req.wr & ~bank_busy[bank_sel];

   // Banks power up cleared
   initial begin
      for (int b = 0; b < words_per_line; b++) begin
         for (int r = 0; r < 2 ** row_w; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   // Busy countdown, reloaded on each accepted access
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < words_per_line; b++) begin
            busy_cnt[b] <= '0;
         end
         vld_pipe <= '0;
      end else begin
         for (int b = 0; b < words_per_line; b++) begin
            if (bank_acc[b]) begin
               busy_cnt[b] <= busy_w'(bank_busy_cycles - 1);
            end else if (bank_busy[b]) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
         vld_pipe[0] <= rd_acc;
         for (int i = 1; i < read_latency; i++) begin
            vld_pipe[i] <= vld_pipe[i-1];
         end
      end
   end

   // Bank array and data stages
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         bank_mem[bank_sel][row] <= mem_req.data;
      end
      data_pipe[0] <= bank_mem[bank_sel][row];
      for (int i = 1; i < read_latency; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   assign mem_rsp = '{data: data_pipe[read_latency-1],
                      data_valid: vld_pipe[read_latency-1],
                      stall: strobe & bank_busy[bank_sel]};

   // A bank takes nothing else until its busy window has run out
   if (bank_busy_cycles > 1) begin : g_busy_chk
      for (genvar b = 0; b < words_per_line; b++) begin : g_bank
         assert property (@(posedge clk) disable iff (reset)
            bank_acc[b] |=> !bank_acc[b] [*bank_busy_cycles-1]);
      end
   end

endmodule

`default_nettype wire

// File: hw/cache_array.sv
// Direct-mapped cache storage
// 256 lines of four words with tag, valid and dirty state.
// Response is registered one cycle after enable
`default_nettype none

module cache_array import mem_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  cache_req_t cache_req,
   output cache_rsp_t cache_rsp
);

   localparam int lines  = 2 ** index_w;
   localparam int word_w = $clog2(words_per_line);

   // Line storage
   logic [tag_w-1:0]  tag_mem  [lines];
   logic [data_w-1:0] data_mem [lines][words_per_line];
   logic [lines-1:0]  valid_bits;
   logic [lines-1:0]  dirty_bits;

   cache_addr_u        req_addr;
   logic [index_w-1:0] idx;
   logic [word_w-1:0]  word;
   logic               tag_match;
   logic               comp_wr;
   logic               fill_wr;

   // Registered response
   logic               hit_q;
   logic               valid_q;
   logic               dirty_q;
   logic [tag_w-1:0]   tag_q;
   logic [data_w-1:0]  data_q;

   assign req_addr = cache_req.addr;
   assign idx      = req_addr.f.index;
   assign word     = req_addr.f.word;

   // Tag compare only, valid is left to the controller
   assign tag_match = tag_mem[idx] == req_addr.f.tag;

   // Compare write lands only on a real hit
   assign comp_wr = cache_req.en & cache_req.write & cache_req.comp &
                    tag_match & valid_bits[idx];
   // Direct write from a line fill
   assign fill_wr = cache_req.en & cache_req.write & ~cache_req.comp;

   // Line state and response flags
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
         hit_q      <= 1'b0;
         valid_q    <= 1'b0;
         dirty_q    <= 1'b0;
      end else begin
         if (cache_req.en) begin
            hit_q   <= tag_match;
            valid_q <= valid_bits[idx];
            dirty_q <= dirty_bits[idx];
         end
         // Fill installs the line clean
         if (fill_wr) begin
            valid_bits[idx] <= cache_req.valid_in;
            dirty_bits[idx] <= 1'b0;
         end else if (comp_wr) begin
            dirty_bits[idx] <= 1'b1;
         end
      end
   end

   // Tag and data arrays, read before write
   always_ff @(posedge clk) begin
      if (cache_req.en) begin
         tag_q  <= tag_mem[idx];
         data_q <= data_mem[idx][word];
      end
      if (fill_wr) begin
         tag_mem[idx] <= req_addr.f.tag;
      end
      if (fill_wr || comp_wr) begin
         data_mem[idx][word] <= cache_req.data;
      end
   end

   assign cache_rsp = '{hit: hit_q, valid: valid_q, dirty: dirty_q,
                        tag_out: tag_q, data: data_q};

   // Controller never writes without enabling the array
   assert property (@(posedge clk) disable iff (reset)
      cache_req.write |-> cache_req.en);

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
// Memory system shared definitions
// Address geometry of the direct-mapped cache and the four-bank memory,
// plus the request and response bundles between controller, cache and memory
`default_nettype none

package mem_pkg;

   // Word and address geometry
   localparam int addr_w         = 16;
   localparam int data_w         = 16;
   localparam int tag_w          = 5;
   localparam int index_w        = 8;
   localparam int words_per_line = 4;

   // Byte address split as tag, index, word offset, byte bit
   typedef struct packed {
      logic [tag_w-1:0]                  tag;
      logic [index_w-1:0]                index;
      logic [$clog2(words_per_line)-1:0] word;
      logic                              byte_sel;
   } cache_addr_fields_t;

   // Same word, flat or split
   typedef union packed {
      logic [addr_w-1:0]  flat;
      cache_addr_fields_t f;
   } cache_addr_u;

   // Controller to cache array
   typedef struct packed {
      logic              en;
      logic              comp;
      logic              write;
      logic              valid_in;
      cache_addr_u       addr;
      logic [data_w-1:0] data;
   } cache_req_t;

   // Cache array to controller, registered
   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [tag_w-1:0]  tag_out;
      logic [data_w-1:0] data;
   } cache_rsp_t;

   // Controller to banked memory
   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } mem_req_t;

   // Banked memory to controller
   typedef struct packed {
      logic [data_w-1:0] data;
      logic              data_valid;
      logic              stall;
   } mem_rsp_t;

endpackage

`default_nettype wire
